// File: hw/fu_add_geom_pkg.sv
//####################################################################
// Datapath geometry of the significand adder stage
// Widths of the full result, the incrementer and the section adder
// Section and byte-group counts, to-integer overflow bit positions
// Vector types for the result, its upper and lower parts, the carry
// input and the per-section control vectors
//####################################################################

package fu_add_geom_pkg;

   localparam int ADD_W      = 163;
   localparam int INC_W      = 53;
   localparam int SUM_W      = 110;
   // Carry vector covers result positions 53..161; position 162 has no carry
   localparam int CRY_W      = 109;

   localparam int SEC_W      = 16;
   localparam int SEC_N      = 7;
   localparam int SEC_LAST_W = 14;

   // Six full byte groups plus one 5-bit group at the bottom of the upper part
   localparam int INC_BYTE_N = 7;
   localparam int INC_BYTE_W = 8;

   localparam int OVF_WD_POS = 130;
   localparam int OVF_DW_POS = 98;

   // Bit 0 is the most significant bit of every vector
   typedef logic [0:ADD_W-1] fu_res_t;
   typedef logic [0:INC_W-1] fu_hi_t;
   typedef logic [0:SUM_W-1] fu_lo_t;
   typedef logic [0:CRY_W-1] fu_cry_t;
   typedef logic [0:SEC_N-1] fu_sec_t;

endpackage

// File: hw/fu_add_ctl_pkg.sv
//####################################################################
// Control and flag bundles of the significand adder stage
// Operation control at ex3, aligner and classifier signals at ex4
// Condition flags and the per-section result select controls
//####################################################################

package fu_add_ctl_pkg;

   typedef struct packed {
      logic effsub;
      logic prod_z;
   } fu_eff_t;

   typedef struct packed {
      logic frc_sel_p1;
      logic sticky;
   } fu_alg_t;

   typedef struct packed {
      logic is_gt;
      logic is_lt;
      logic is_eq;
      logic is_nan;
      logic cmp_sgnpos;
      logic cmp_sgnneg;
   } fu_pic_t;

   typedef struct packed {
      logic nan;
      logic gt;
      logic lt;
      logic eq;
   } fu_cc_t;

   // sel_p0 and sel_p1 pick the carry-in zero or one sum, sel_p0n inverts the pick
   typedef struct packed {
      fu_add_geom_pkg::fu_sec_t sel_p0n;
      fu_add_geom_pkg::fu_sec_t sel_p0;
      fu_add_geom_pkg::fu_sec_t sel_p1;
   } fu_sel_t;

endpackage

// File: hw/fu_add_inc.sv
//####################################################################
// Upper 53-bit incrementer
// Per byte group +0 and +1 values with group carries from the
// all-ones terms of the lower groups
// All-ones detect and the final select and invert of the upper part
//####################################################################

`timescale 1ns/1ps

module fu_add_inc (
   input  fu_add_geom_pkg::fu_hi_t s_hi,
   input  logic                    inc_sel,
   input  logic                    inc_flip,
   output logic                    inc_all1,
   output fu_add_geom_pkg::fu_hi_t res_hi
);
   import fu_add_geom_pkg::*;

   logic [0:INC_BYTE_N-1] byt_all1;
   logic [0:INC_BYTE_N-1] byt_ci;
   fu_hi_t                inc_p1;

   for (genvar b = 0; b < INC_BYTE_N; b++) begin : g_byt
      // The last group holds whatever is left below the full bytes
      localparam int BW = (b == INC_BYTE_N - 1) ? INC_W - INC_BYTE_W * b : INC_BYTE_W;
      logic [0:BW-1] x;

      assign x           = s_hi[INC_BYTE_W * b +: BW];
      assign byt_all1[b] = &x;
      assign inc_p1[INC_BYTE_W * b +: BW] = byt_ci[b] ? x + BW'(1) : x;
   end

   // A group increments when every group below it is all ones
   always_comb begin : byt_carry
      logic run;
      run = 1'b1;
      for (int b = INC_BYTE_N - 1; b >= 0; b--) begin
         byt_ci[b] = run;
         run       = run & byt_all1[b];
      end
   end

   assign inc_all1 = &byt_all1;

   assign res_hi = (inc_sel ? inc_p1 : s_hi) ^ {INC_W{inc_flip}};

endmodule

// File: hw/fu_add_hc16.sv
//####################################################################
// One conditional-sum adder section
// Section sums for a carry-in of zero and of one
// Section generate and transmit for the global carry network
//####################################################################

`timescale 1ns/1ps

module fu_add_hc16 #(
   parameter int SEC_BITS = fu_add_geom_pkg::SEC_W
) (
   input  logic [0:SEC_BITS-1] x,
   input  logic [0:SEC_BITS-1] y,
   output logic [0:SEC_BITS-1] s0,
   output logic [0:SEC_BITS-1] s1,
   output logic                g16,
   output logic                t16
);

   logic [0:SEC_BITS] xe;
   logic [0:SEC_BITS] ye;

   assign xe = {1'b0, x};
   assign ye = {1'b0, y};

   // Generate is the carry out with no carry in, transmit the carry out with one
   assign {g16, s0} = xe + ye;
   assign {t16, s1} = xe + ye + (SEC_BITS + 1)'(1);

endmodule

// File: hw/fu_add_sum.sv
//####################################################################
// Lower 110-bit adder built from seven sections
// Six 16-bit sections and one 14-bit section at the bottom
// Per-section choice of the carry-in zero or one sum, with inversion
//####################################################################

`timescale 1ns/1ps

module fu_add_sum (
   input  fu_add_geom_pkg::fu_lo_t  s_lo,
   input  fu_add_geom_pkg::fu_cry_t cry,
   input  fu_add_ctl_pkg::fu_sel_t  sel,
   output fu_add_geom_pkg::fu_sec_t g16,
   output fu_add_geom_pkg::fu_sec_t t16,
   output fu_add_geom_pkg::fu_lo_t  res_lo
);
   import fu_add_geom_pkg::*;

   fu_lo_t c_ext;

   // Carry vector sits one position up, with a zero at the bottom
   assign c_ext = {cry, 1'b0};

   for (genvar i = 0; i < SEC_N; i++) begin : g_sec
      localparam int W = (i == SEC_N - 1) ? SEC_LAST_W : SEC_W;
      logic [0:W-1] p0;
      logic [0:W-1] p1;
      logic [0:W-1] pick;

      fu_add_hc16 #(.SEC_BITS(W)) u_hc (
         .x   (s_lo[SEC_W * i +: W]),
         .y   (c_ext[SEC_W * i +: W]),
         .s0  (p0),
         .s1  (p1),
         .g16 (g16[i]),
         .t16 (t16[i])
      );

      assign pick = ({W{sel.sel_p0[i]}} & p0) | ({W{sel.sel_p1[i]}} & p1);

      // Inversion follows the picked sum so a carried-into section inverts p1
      assign res_lo[SEC_W * i +: W] = pick ^ {W{sel.sel_p0n[i]}};
   end

endmodule

// File: hw/fu_add_glbc.sv
//####################################################################
// Global carry network of the section adder
// Operation decode latched from ex3 to ex4
// Carry out, end-around carry and section carry-ins
// Section selects, upper select and invert, and sign carry
//####################################################################

`timescale 1ns/1ps

module fu_add_glbc (
   input  logic                     nclk,
   input  logic                     rst_n,
   input  logic                     ex3_act,
   input  fu_add_ctl_pkg::fu_eff_t  ex3_eff,
   input  fu_add_geom_pkg::fu_sec_t g16,
   input  fu_add_geom_pkg::fu_sec_t t16,
   input  logic                     inc_all1,
   input  logic                     frc_sel_p1,
   output fu_add_ctl_pkg::fu_sel_t  sel,
   output logic                     inc_sel,
   output logic                     inc_flip,
   output logic                     sign_carry
);
   import fu_add_geom_pkg::*;

   logic    ex4_effsub;
   logic    ex4_effsub_npz;
   logic    ex4_effadd_npz;
   logic    ex4_prod_z;
   fu_sec_t ci0;
   fu_sec_t ci1;
   fu_sec_t sel_p1;
   logic    co;
   logic    eac;
   logic    inv;

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         ex4_effsub     <= 1'b0;
         ex4_effsub_npz <= 1'b0;
         ex4_effadd_npz <= 1'b0;
      end else if (ex3_act) begin
         ex4_effsub     <= ex3_eff.effsub;
         ex4_effsub_npz <= ex3_eff.effsub & ~ex3_eff.prod_z;
         ex4_effadd_npz <= ~ex3_eff.effsub & ~ex3_eff.prod_z;
      end
   end

   assign ex4_prod_z = ~(ex4_effsub_npz | ex4_effadd_npz);

   // Section carry-ins for a bottom carry of zero and of one
   always_comb begin : carry_chain
      logic cy0;
      logic cy1;
      cy0 = 1'b0;
      cy1 = 1'b1;
      for (int i = SEC_N - 1; i >= 0; i--) begin
         ci0[i] = cy0;
         ci1[i] = cy1;
         cy0    = g16[i] | (t16[i] & cy0);
         cy1    = g16[i] | (t16[i] & cy1);
      end
      co = cy0;
   end

   // Subtract with a carry out feeds it back in at the bottom
   assign eac = ex4_effsub & co;
   // Subtract without one gives a negative sum that is complemented
   assign inv = ex4_effsub & ~ex4_prod_z & ~co;

   assign sel_p1 = eac ? ci1 : ci0;
   assign sel    = '{sel_p0n: {SEC_N{inv}}, sel_p0: ~sel_p1, sel_p1: sel_p1};

   assign inc_sel  = co | (~ex4_effsub & frc_sel_p1);
   assign inc_flip = inv;

   // On an add the sign carry is the overflow of an all-ones upper part
   assign sign_carry = ex4_effsub ? co : (inc_sel & inc_all1);

endmodule

// File: hw/fu_add_fpcc.sv
//####################################################################
// Compare condition flags
// Zero detect of the combined result
// nan, eq, gt and lt in priority order from the classifier inputs
//####################################################################

`timescale 1ns/1ps

module fu_add_fpcc (
   input  fu_add_geom_pkg::fu_res_t res,
   input  logic                     sign_carry,
   input  fu_add_ctl_pkg::fu_pic_t  pic,
   output fu_add_ctl_pkg::fu_cc_t   cc
);

   logic res_z;
   logic arith;
   logic nan;
   logic eq;
   logic gt;
   logic lt;

   assign res_z = ~|res;
   assign arith = pic.cmp_sgnpos | pic.cmp_sgnneg;

   // nan wins over everything, then eq, then gt, and lt takes the rest
   assign nan = pic.is_nan;
   assign eq  = ~nan & (pic.is_eq | (arith & res_z));
   assign gt  = ~nan & ~eq & (pic.is_gt | (pic.cmp_sgnpos & sign_carry) |
                              (pic.cmp_sgnneg & ~sign_carry));
   assign lt  = ~nan & ~eq & ~gt & (pic.is_lt | arith);

   assign cc = '{nan: nan, gt: gt, lt: lt, eq: eq};

endmodule

// File: hw/fu_add_ex5_lat.sv
//####################################################################
// Act pipeline from ex2 to ex4
// ex5 registers for the result, flags, sign carry and sticky
// To-integer overflow taps on the registered result
//####################################################################

`timescale 1ns/1ps

module fu_add_ex5_lat (
   input  logic                     nclk,
   input  logic                     rst_n,
   input  logic                     ex2_act,
   input  fu_add_geom_pkg::fu_res_t ex4_res,
   input  fu_add_ctl_pkg::fu_cc_t   ex4_cc,
   input  logic                     ex4_sign_carry,
   input  logic                     ex4_sticky,
   output logic                     ex3_act,
   output fu_add_geom_pkg::fu_res_t res,
   output fu_add_ctl_pkg::fu_cc_t   cc,
   output logic                     sign_carry,
   output logic                     sticky,
   output logic [0:1]               ovf_wd,
   output logic [0:1]               ovf_dw
);
   import fu_add_geom_pkg::*;

   logic ex4_act;

   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         ex3_act <= 1'b0;
         ex4_act <= 1'b0;
      end else begin
         ex3_act <= ex2_act;
         ex4_act <= ex3_act;
      end
   end

   // Outputs hold their value until the next operation reaches ex4
   always_ff @(posedge nclk or negedge rst_n) begin
      if (!rst_n) begin
         res        <= '0;
         cc         <= '0;
         sign_carry <= 1'b0;
         sticky     <= 1'b0;
      end else if (ex4_act) begin
         res        <= ex4_res;
         cc         <= ex4_cc;
         sign_carry <= ex4_sign_carry;
         sticky     <= ex4_sticky;
      end
   end

   assign ovf_wd = res[OVF_WD_POS +: 2];
   assign ovf_dw = res[OVF_DW_POS +: 2];

endmodule

// File: hw/fu_add.sv
//####################################################################
// Significand adder stage top level
// Upper incrementer, lower section adder and global carry network
// Compare flag logic and the ex5 result and flag registers
//####################################################################

`timescale 1ns/1ps

module fu_add (
   input  logic                     nclk,
   input  logic                     rst_n,
   input  logic                     ex2_act,
   input  fu_add_ctl_pkg::fu_eff_t  ex3_eff,
   input  fu_add_geom_pkg::fu_res_t sum_in,
   input  fu_add_geom_pkg::fu_cry_t cry_in,
   input  fu_add_ctl_pkg::fu_alg_t  alg,
   input  fu_add_ctl_pkg::fu_pic_t  pic,
   output fu_add_geom_pkg::fu_res_t res,
   output fu_add_ctl_pkg::fu_cc_t   cc,
   output logic                     sign_carry,
   output logic                     sticky,
   output logic [0:1]               ovf_wd,
   output logic [0:1]               ovf_dw
);
   import fu_add_geom_pkg::*;
   import fu_add_ctl_pkg::*;

   logic    ex3_act;
   fu_sec_t ex4_g16;
   fu_sec_t ex4_t16;
   fu_sel_t ex4_sel;
   logic    ex4_inc_all1;
   logic    ex4_inc_sel;
   logic    ex4_inc_flip;
   logic    ex4_sign_carry;
   fu_hi_t  ex4_res_hi;
   fu_lo_t  ex4_res_lo;
   fu_res_t ex4_res;
   fu_cc_t  ex4_cc;

   assign ex4_res = {ex4_res_hi, ex4_res_lo};

   fu_add_inc u_inc (
      .s_hi     (sum_in[0 +: INC_W]),
      .inc_sel  (ex4_inc_sel),
      .inc_flip (ex4_inc_flip),
      .inc_all1 (ex4_inc_all1),
      .res_hi   (ex4_res_hi)
   );

   fu_add_sum u_sum (
      .s_lo   (sum_in[INC_W +: SUM_W]),
      .cry    (cry_in),
      .sel    (ex4_sel),
      .g16    (ex4_g16),
      .t16    (ex4_t16),
      .res_lo (ex4_res_lo)
   );

   fu_add_glbc u_glbc (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .ex3_act    (ex3_act),
      .ex3_eff    (ex3_eff),
      .g16        (ex4_g16),
      .t16        (ex4_t16),
      .inc_all1   (ex4_inc_all1),
      .frc_sel_p1 (alg.frc_sel_p1),
      .sel        (ex4_sel),
      .inc_sel    (ex4_inc_sel),
      .inc_flip   (ex4_inc_flip),
      .sign_carry (ex4_sign_carry)
   );

   fu_add_fpcc u_fpcc (
      .res        (ex4_res),
      .sign_carry (ex4_sign_carry),
      .pic        (pic),
      .cc         (ex4_cc)
   );

   fu_add_ex5_lat u_ex5 (
      .nclk           (nclk),
      .rst_n          (rst_n),
      .ex2_act        (ex2_act),
      .ex4_res        (ex4_res),
      .ex4_cc         (ex4_cc),
      .ex4_sign_carry (ex4_sign_carry),
      .ex4_sticky     (alg.sticky),
      .ex3_act        (ex3_act),
      .res            (res),
      .cc             (cc),
      .sign_carry     (sign_carry),
      .sticky         (sticky),
      .ovf_wd         (ovf_wd),
      .ovf_dw         (ovf_dw)
   );

endmodule

// File: tests/fu_add_tb_model.svh
//####################################################################
// Testbench reference model of the significand adder stage
// Galois LFSR bit source and wide random words
// Expected result, sign carry, flags and sticky of one operation
//####################################################################

`ifndef FU_ADD_TB_MODEL_SVH
`define FU_ADD_TB_MODEL_SVH

   // Galois form of x^32 + x^22 + x^2 + x + 1, one output bit per step
   function automatic logic rand_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b)
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [255:0] rand_bits(int n);
      logic [255:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[254:0], rand_bit()};
      return v;
   endfunction

   function automatic exp_t model_op(op_t op);
      fu_hi_t         s_hi;
      fu_hi_t         hi;
      fu_lo_t         lo;
      fu_lo_t         l_sum;
      logic [SUM_W:0] wide;
      logic           co;
      logic           inc;
      logic           sc;
      logic           z;
      logic           arith;
      exp_t           e;
      s_hi  = op.sum[0 +: INC_W];
      wide  = {1'b0, op.sum[INC_W +: SUM_W]} + {1'b0, op.cry, 1'b0};
      co    = wide[SUM_W];
      l_sum = wide[SUM_W-1:0];
      if (!op.eff.effsub) begin
         inc = co | op.alg.frc_sel_p1;
         hi  = inc ? s_hi + fu_hi_t'(1) : s_hi;
         lo  = l_sum;
         sc  = inc & (&s_hi);
      end else if (co) begin
         // End-around carry
         hi = s_hi + fu_hi_t'(1);
         lo = l_sum + fu_lo_t'(1);
         sc = 1'b1;
      end else begin
         hi = op.eff.prod_z ? s_hi : ~s_hi;
         lo = op.eff.prod_z ? l_sum : ~l_sum;
         sc = 1'b0;
      end
      e.res        = {hi, lo};
      e.sign_carry = sc;
      e.sticky     = op.alg.sticky;
      z     = ~|e.res;
      arith = op.pic.cmp_sgnpos | op.pic.cmp_sgnneg;
      e.cc.nan = op.pic.is_nan;
      e.cc.eq  = ~e.cc.nan & (op.pic.is_eq | (arith & z));
      e.cc.gt  = ~e.cc.nan & ~e.cc.eq &
                 (op.pic.is_gt | (op.pic.cmp_sgnpos & sc) | (op.pic.cmp_sgnneg & ~sc));
      e.cc.lt  = ~e.cc.nan & ~e.cc.eq & ~e.cc.gt & (op.pic.is_lt | arith);
      return e;
   endfunction

`endif

// File: tests/fu_add_tb.sv
//####################################################################
// Testbench for the significand adder stage
// Clock, reset and an overlapping three-cycle operation schedule
// Expected-value queue and per-cycle assertions on the ex5 outputs
// Cycle-count timeout
//####################################################################

`timescale 1ns/1ps

module fu_add_tb;
   import fu_add_geom_pkg::*;
   import fu_add_ctl_pkg::*;

   localparam int N_OPS   = 64;
   localparam int RST_CYC = 16;
   localparam int MAX_CYC = 3 * N_OPS + RST_CYC;

   typedef struct packed {
      fu_eff_t eff;
      fu_res_t sum;
      fu_cry_t cry;
      fu_alg_t alg;
      fu_pic_t pic;
   } op_t;

   typedef struct packed {
      fu_res_t res;
      fu_cc_t  cc;
      logic    sign_carry;
      logic    sticky;
   } exp_t;

   logic        nclk;
   logic        rst_n;
   logic        ex2_act;
   fu_eff_t     ex3_eff;
   fu_res_t     sum_in;
   fu_cry_t     cry_in;
   fu_alg_t     alg;
   fu_pic_t     pic;
   fu_res_t     res;
   fu_cc_t      cc;
   logic        sign_carry;
   logic        sticky;
   logic [0:1]  ovf_wd;
   logic [0:1]  ovf_dw;
   logic [31:0] lfsr_state;
   exp_t        exp_q[$];
   exp_t        cur;
   logic [1:0]  seen;
   int          n_checked;
   int          cycles = 0;

   `include "fu_add_tb_model.svh"

   fu_add uut (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .ex2_act    (ex2_act),
      .ex3_eff    (ex3_eff),
      .sum_in     (sum_in),
      .cry_in     (cry_in),
      .alg        (alg),
      .pic        (pic),
      .res        (res),
      .cc         (cc),
      .sign_carry (sign_carry),
      .sticky     (sticky),
      .ovf_wd     (ovf_wd),
      .ovf_dw     (ovf_dw)
   );

   task automatic stop_with(string line);
      $display("%s", line);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   // Kinds 0 and 1 add, the others subtract; 3 gives a zero result on a compare
   function automatic op_t make_op(int kind);
      op_t op;
      op.eff = fu_eff_t'(rand_bits(2));
      op.sum = fu_res_t'(rand_bits(ADD_W));
      op.cry = fu_cry_t'(rand_bits(CRY_W));
      op.alg = fu_alg_t'(rand_bits(2));
      op.pic = fu_pic_t'(rand_bits(6));
      op.eff.effsub = (kind > 1);
      case (kind)
         1: begin
            op.sum[0 +: INC_W]   = '1;
            op.alg.frc_sel_p1    = 1'b1;
         end
         3: begin
            op.eff.prod_z          = 1'b0;
            op.sum[0 +: INC_W]     = '1;
            op.sum[INC_W +: SUM_W] = ~{op.cry, 1'b0};
            op.pic                 = '0;
            op.pic.cmp_sgnpos      = rand_bit();
            op.pic.cmp_sgnneg      = ~op.pic.cmp_sgnpos;
         end
         4: begin
            op.sum[INC_W +: SUM_W] = '1;
            op.cry[CRY_W-1]        = 1'b1;
         end
         5: begin
            op.cry        = '0;
            op.sum[INC_W] = 1'b0;
            op.pic        = op.pic & 6'b000011;
         end
         default: ;
      endcase
      return op;
   endfunction

   initial begin
      nclk = 1'b0;
      forever #20 nclk = ~nclk;
   end

   always @(posedge nclk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYC)
         stop_with($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYC));
   end

   // The result of an operation started at edge e is checked from edge e+4 on
   always @(posedge nclk) begin
      if (!rst_n) begin
         n_checked = 0;
         cur      <= '0;
         seen     <= '0;
      end else begin
         if (seen[1]) begin
            if (exp_q.size() == 0)
               stop_with("A result reached ex5 with no expected value queued");
            else begin
               cur <= exp_q.pop_front();
               n_checked++;
            end
         end
         seen <= {seen[0], ex2_act};
      end
   end

   assert property (@(posedge nclk) disable iff (!rst_n) res === cur.res)
      else stop_with($sformatf("FAILED at %0d ns: res %h, expected %h",
                               $time, $sampled(res), $sampled(cur.res)));
   assert property (@(posedge nclk) disable iff (!rst_n) cc === cur.cc)
      else stop_with($sformatf("FAILED at %0d ns: cc %b, expected %b",
                               $time, $sampled(cc), $sampled(cur.cc)));
   assert property (@(posedge nclk) disable iff (!rst_n) sign_carry === cur.sign_carry)
      else stop_with($sformatf("FAILED at %0d ns: sign_carry %b, expected %b",
                               $time, $sampled(sign_carry), $sampled(cur.sign_carry)));
   assert property (@(posedge nclk) disable iff (!rst_n) sticky === cur.sticky)
      else stop_with($sformatf("FAILED at %0d ns: sticky %b, expected %b",
                               $time, $sampled(sticky), $sampled(cur.sticky)));
   assert property (@(posedge nclk) disable iff (!rst_n)
                    ovf_wd === cur.res[OVF_WD_POS +: 2])
      else stop_with($sformatf("FAILED at %0d ns: ovf_wd %b, expected %b",
                               $time, $sampled(ovf_wd),
                               $sampled(cur.res[OVF_WD_POS +: 2])));
   assert property (@(posedge nclk) disable iff (!rst_n)
                    ovf_dw === cur.res[OVF_DW_POS +: 2])
      else stop_with($sformatf("FAILED at %0d ns: ovf_dw %b, expected %b",
                               $time, $sampled(ovf_dw),
                               $sampled(cur.res[OVF_DW_POS +: 2])));

   initial begin : stimulus
      op_t  op_a;
      op_t  op_b;
      op_t  op_n;
      logic v_a;
      logic v_b;
      logic start;
      int   started;
      int   gap;
      lfsr_state = 32'h263d;
      rst_n      = 1'b0;
      ex2_act    = 1'b0;
      ex3_eff    = '0;
      sum_in     = '0;
      cry_in     = '0;
      alg        = '0;
      pic        = '0;
      op_a       = '0;
      op_b       = '0;
      v_a        = 1'b0;
      v_b        = 1'b0;
      started    = 0;
      gap        = 0;
      repeat (RST_CYC) @(posedge nclk);
      rst_n <= 1'b1;
      while (started < N_OPS || v_a || v_b) begin
         op_n  = '0;
         start = (started < N_OPS) && (gap == 0);
         if (gap > 0)
            gap--;
         if (start) begin
            op_n = make_op(started % 6);
            exp_q.push_back(model_op(op_n));
            started++;
            // An idle stretch every 16 operations, where the outputs must hold
            if (started % 16 == 0)
               gap = 5;
         end
         @(posedge nclk);
         ex2_act <= start;
         ex3_eff <= v_a ? op_a.eff : ~ex3_eff;
         sum_in  <= v_b ? op_b.sum : ~sum_in;
         cry_in  <= v_b ? op_b.cry : ~cry_in;
         alg     <= v_b ? op_b.alg : ~alg;
         pic     <= v_b ? op_b.pic : ~pic;
         op_b = op_a;
         v_b  = v_a;
         op_a = op_n;
         v_a  = start;
      end
      repeat (6) @(posedge nclk);
      if (n_checked != N_OPS || exp_q.size() != 0) begin
         stop_with($sformatf("Only %0d of %0d results were checked", n_checked, N_OPS));
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

// File: files.f
+incdir+tests
hw/fu_add_geom_pkg.sv
hw/fu_add_ctl_pkg.sv
hw/fu_add_inc.sv
hw/fu_add_hc16.sv
hw/fu_add_sum.sv
hw/fu_add_glbc.sv
hw/fu_add_fpcc.sv
hw/fu_add_ex5_lat.sv
hw/fu_add.sv
tests/fu_add_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module fu_add_tb -o fu_add_sim \
   && ./obj_dir/fu_add_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
